// ==== sim.f ====
cpu16_pkg.sv
fetch_unit.sv
stall_logic.sv
execute_unit.sv
mem_writeback.sv
cpu16_top.sv
tb_cpu16.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module tb_cpu16 -f sim.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_cpu16)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "sim passed"; then
	exit 0
fi
exit 1

// ==== tb_cpu16.sv ====
module tb_cpu16;
	timeunit 1ns;
	timeprecision 1ps;

	// DUT ports
	logic clk;
	logic rst_n;
	logic prog_we;
	logic [cpu16_pkg::mem_aw-1:0] prog_addr;
	logic [cpu16_pkg::word_w-1:0] prog_data;
	logic run;
	logic [cpu16_pkg::mem_aw-1:0] host_addr;
	logic [cpu16_pkg::word_w-1:0] host_rdata;
	logic halted;
	logic retire_valid;
	logic retire_wen;
	logic [cpu16_pkg::reg_aw-1:0] retire_reg;
	logic [cpu16_pkg::word_w-1:0] retire_data;

	// ISA model state, the register file and data memory keep their contents across resets
	logic [cpu16_pkg::word_w-1:0] model_reg [0:(1 << cpu16_pkg::reg_aw)-1];
	logic [cpu16_pkg::word_w-1:0] model_mem [0:(1 << cpu16_pkg::mem_aw)-1];
	bit model_known [0:(1 << cpu16_pkg::mem_aw)-1];
	bit model_zero;
	logic [cpu16_pkg::word_w-1:0] last_instr;
	bit have_last;

	// Program under test and expected trace
	logic [cpu16_pkg::word_w-1:0] prog [$];
	bit exp_wen [$];
	logic [cpu16_pkg::reg_aw-1:0] exp_reg [$];
	logic [cpu16_pkg::word_w-1:0] exp_data [$];
	int exp_gap [$];
	// Observed trace
	bit act_wen [$];
	logic [cpu16_pkg::reg_aw-1:0] act_reg [$];
	logic [cpu16_pkg::word_w-1:0] act_data [$];
	int act_cycle [$];

	int errors;
	int checks;
	int tests;
	int err_mark;
	bit timed_out;
	integer seed;

	cpu16_top uut (
		.clk, .rst_n, .prog_we, .prog_addr, .prog_data, .run, .host_addr, .host_rdata,
		.halted, .retire_valid, .retire_wen, .retire_reg, .retire_data
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic check_word(input string name, input logic [cpu16_pkg::word_w-1:0] got,
		input logic [cpu16_pkg::word_w-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_reg(input string name, input logic [cpu16_pkg::reg_aw-1:0] got,
		input logic [cpu16_pkg::reg_aw-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_gap(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	// Encoders, register form and byte immediate form
	function automatic logic [cpu16_pkg::word_w-1:0] rtype(input logic [3:0] op, input int rd,
		input int rs, input int rt);
		return {op, rd[3:0], rs[3:0], rt[3:0]};
	endfunction

	function automatic logic [cpu16_pkg::word_w-1:0] itype(input logic [3:0] op, input int rd,
		input int imm);
		return {op, rd[3:0], imm[7:0]};
	endfunction

	// R0 always reads zero
	function automatic logic [cpu16_pkg::word_w-1:0] model_read(input logic [3:0] r);
		return (r == '0) ? '0 : model_reg[r];
	endfunction

	// Source fields that the load-use rule looks at
	function automatic bit reads_reg(input logic [cpu16_pkg::word_w-1:0] instr,
		input logic [3:0] r);
		logic [3:0] op;
		op = instr[15:12];
		if (op inside {cpu16_pkg::op_add, cpu16_pkg::op_addz, cpu16_pkg::op_sub,
			cpu16_pkg::op_and, cpu16_pkg::op_nor}) begin
			return (instr[7:4] == r) || (instr[3:0] == r);
		end
		if (op inside {cpu16_pkg::op_sll, cpu16_pkg::op_srl, cpu16_pkg::op_sra,
			cpu16_pkg::op_lw}) begin
			return instr[7:4] == r;
		end
		// sw data register sits in rd
		if (op == cpu16_pkg::op_sw) begin
			return instr[11:8] == r;
		end
		return 1'b0;
	endfunction

	// One instruction of the ISA, pushes its expected trace entry
	task automatic model_exec(input logic [cpu16_pkg::word_w-1:0] instr);
		logic [3:0] op;
		logic [3:0] rd;
		logic [3:0] rs;
		logic [3:0] rt;
		logic [cpu16_pkg::word_w-1:0] a;
		logic [cpu16_pkg::word_w-1:0] b;
		logic [cpu16_pkg::word_w-1:0] res;
		logic [cpu16_pkg::word_w-1:0] addr_sum;
		bit wen;
		int gap;
		op = instr[15:12];
		rd = instr[11:8];
		rs = instr[7:4];
		rt = instr[3:0];
		a = model_read(rs);
		b = model_read(rt);
		// Memory address is rs plus signed imm4
		addr_sum = a + {{12{rt[3]}}, rt};
		res = '0;
		wen = 1'b1;
		case (op)
			cpu16_pkg::op_add: res = a + b;
			cpu16_pkg::op_addz: begin
				res = a + b;
				wen = model_zero;
			end
			cpu16_pkg::op_sub: res = a - b;
			cpu16_pkg::op_and: res = a & b;
			cpu16_pkg::op_nor: res = ~(a | b);
			cpu16_pkg::op_sll: res = a << rt;
			cpu16_pkg::op_srl: res = a >> rt;
			cpu16_pkg::op_sra: res = $signed(a) >>> rt;
			cpu16_pkg::op_lw: res = model_mem[addr_sum[7:0]];
			cpu16_pkg::op_sw: begin
				model_mem[addr_sum[7:0]] = model_read(rd);
				model_known[addr_sum[7:0]] = 1'b1;
				wen = 1'b0;
			end
			cpu16_pkg::op_lhb: res = {instr[7:0], 8'h00};
			cpu16_pkg::op_llb: res = {{8{instr[7]}}, instr[7:0]};
			// hlt and the control flow group
			default: wen = 1'b0;
		endcase
		// Zero flag follows the executed arithmetic and logic group
		if (wen && (op inside {cpu16_pkg::op_add, cpu16_pkg::op_addz, cpu16_pkg::op_sub,
			cpu16_pkg::op_and, cpu16_pkg::op_nor})) begin
			model_zero = (res == '0);
		end
		if (wen) begin
			model_reg[rd] = res;
		end
		// Load then dependent reader costs two extra cycles
		gap = 1;
		if (have_last && last_instr[15:12] == cpu16_pkg::op_lw &&
			reads_reg(instr, last_instr[11:8])) begin
			gap = 3;
		end
		exp_wen.push_back(wen);
		exp_reg.push_back(rd);
		exp_data.push_back(res);
		exp_gap.push_back(gap);
		last_instr = instr;
		have_last = 1'b1;
	endtask

	task automatic add_instr(input logic [cpu16_pkg::word_w-1:0] instr);
		prog.push_back(instr);
		model_exec(instr);
	endtask

	task automatic reset_dut();
		@(posedge clk);
		rst_n <= 1'b0;
		run <= 1'b0;
		prog_we <= 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
	endtask

	task automatic load_program();
		foreach (prog[i]) begin
			@(posedge clk);
			prog_we <= 1'b1;
			prog_addr <= 8'(i);
			prog_data <= prog[i];
		end
		@(posedge clk);
		prog_we <= 1'b0;
	endtask

	// Collects the trace until halted, sampled on the falling edge
	task automatic wait_halted(input int limit);
		int cycles;
		bit done;
		cycles = 0;
		done = 1'b0;
		act_wen.delete();
		act_reg.delete();
		act_data.delete();
		act_cycle.delete();
		while (!done) begin
			@(negedge clk);
			cycles++;
			if (retire_valid) begin
				act_wen.push_back(retire_wen);
				act_reg.push_back(retire_reg);
				act_data.push_back(retire_data);
				act_cycle.push_back(cycles);
			end
			if (halted) begin
				done = 1'b1;
			end else if (cycles >= limit) begin
				timed_out = 1'b1;
				errors++;
				$display("timeout, halted still low after %0d cycles", limit);
				done = 1'b1;
			end
		end
	endtask

	// Reset, load, run to halt and compare the trace with the model
	task automatic run_program();
		int n;
		int i;
		reset_dut();
		load_program();
		@(posedge clk);
		run <= 1'b1;
		wait_halted(300);
		if (timed_out) begin
			return;
		end
		n = exp_wen.size();
		checks++;
		if (act_wen.size() != n) begin
			errors++;
			$display("retired %0d instructions where %0d were expected", act_wen.size(), n);
			if (act_wen.size() < n) begin
				n = act_wen.size();
			end
		end
		for (i = 0; i < n; i++) begin
			check_flag("retire_wen", act_wen[i], exp_wen[i]);
			if (exp_wen[i]) begin
				check_reg("retire_reg", act_reg[i], exp_reg[i]);
				check_word("retire_data", act_data[i], exp_data[i]);
			end
			if (i > 0) begin
				check_gap("retire_valid gap", act_cycle[i] - act_cycle[i-1], exp_gap[i]);
			end
		end
		@(posedge clk);
		run <= 1'b0;
	endtask

	// Host read port, data one cycle after the address
	task automatic check_mem(input logic [cpu16_pkg::mem_aw-1:0] addr);
		@(posedge clk);
		host_addr <= addr;
		@(posedge clk);
		@(negedge clk);
		check_word("host_rdata", host_rdata, model_mem[addr]);
	endtask

	task automatic begin_test();
		prog.delete();
		exp_wen.delete();
		exp_reg.delete();
		exp_data.delete();
		exp_gap.delete();
		// Reset clears the zero flag
		model_zero = 1'b0;
		have_last = 1'b0;
		err_mark = errors;
		tests++;
	endtask

	task automatic end_test(input string name);
		$display("test %0d %s: %s", tests, name, (errors == err_mark) ? "ok" : "errors");
	endtask

	task automatic halt_after_reset();
		int i;
		if (timed_out) begin
			return;
		end
		begin_test();
		reset_dut();
		// Idle core, nothing retires
		for (i = 0; i < 4; i++) begin
			@(negedge clk);
			check_flag("retire_valid", retire_valid, 1'b0);
			check_flag("retire_wen", retire_wen, 1'b0);
			check_flag("halted", halted, 1'b0);
		end
		add_instr(itype(cpu16_pkg::op_hlt, 0, 0));
		run_program();
		end_test("halt after reset");
	endtask

	task automatic alu_chain();
		if (timed_out) begin
			return;
		end
		begin_test();
		// Each step reads the result just before it
		add_instr(itype(cpu16_pkg::op_llb, 1, 'h35));
		add_instr(itype(cpu16_pkg::op_lhb, 2, 'h12));
		add_instr(rtype(cpu16_pkg::op_add, 3, 1, 2));
		add_instr(rtype(cpu16_pkg::op_sub, 4, 3, 1));
		add_instr(rtype(cpu16_pkg::op_and, 5, 4, 3));
		add_instr(rtype(cpu16_pkg::op_nor, 6, 5, 1));
		add_instr(rtype(cpu16_pkg::op_sll, 7, 6, 4));
		add_instr(rtype(cpu16_pkg::op_srl, 8, 7, 3));
		add_instr(rtype(cpu16_pkg::op_sra, 9, 7, 2));
		// Negative byte
		add_instr(itype(cpu16_pkg::op_llb, 10, 'h9C));
		add_instr(itype(cpu16_pkg::op_hlt, 0, 0));
		run_program();
		end_test("alu chain");
	endtask

	task automatic load_use();
		if (timed_out) begin
			return;
		end
		begin_test();
		add_instr(itype(cpu16_pkg::op_llb, 1, 'h20));
		add_instr(itype(cpu16_pkg::op_llb, 2, 'h5A));
		add_instr(rtype(cpu16_pkg::op_sw, 2, 1, 0));
		add_instr(rtype(cpu16_pkg::op_lw, 4, 1, 0));
		add_instr(rtype(cpu16_pkg::op_add, 5, 4, 2));
		add_instr(rtype(cpu16_pkg::op_lw, 6, 1, 0));
		add_instr(rtype(cpu16_pkg::op_sll, 7, 6, 2));
		add_instr(rtype(cpu16_pkg::op_lw, 8, 1, 0));
		// Store data comes straight from the load
		add_instr(rtype(cpu16_pkg::op_sw, 8, 1, 1));
		add_instr(rtype(cpu16_pkg::op_lw, 9, 1, 1));
		// Independent follower, no stall
		add_instr(rtype(cpu16_pkg::op_add, 10, 1, 2));
		add_instr(itype(cpu16_pkg::op_hlt, 0, 0));
		run_program();
		check_mem(8'h20);
		check_mem(8'h21);
		end_test("load use");
	endtask

	task automatic store_offsets();
		if (timed_out) begin
			return;
		end
		begin_test();
		add_instr(itype(cpu16_pkg::op_llb, 1, 'h40));
		add_instr(itype(cpu16_pkg::op_llb, 2, 'h11));
		add_instr(itype(cpu16_pkg::op_lhb, 3, 'hA5));
		add_instr(itype(cpu16_pkg::op_llb, 4, 'h7F));
		add_instr(rtype(cpu16_pkg::op_sw, 2, 1, 7));
		add_instr(rtype(cpu16_pkg::op_sw, 3, 1, -8));
		add_instr(rtype(cpu16_pkg::op_sw, 4, 1, -1));
		// Nonzero word that the R0 store below must overwrite
		add_instr(rtype(cpu16_pkg::op_sw, 2, 1, 2));
		// R0 write shows in the trace only
		add_instr(rtype(cpu16_pkg::op_add, 0, 2, 3));
		add_instr(rtype(cpu16_pkg::op_add, 5, 0, 2));
		add_instr(rtype(cpu16_pkg::op_sw, 0, 1, 2));
		add_instr(itype(cpu16_pkg::op_hlt, 0, 0));
		run_program();
		check_mem(8'h47);
		check_mem(8'h38);
		check_mem(8'h3F);
		check_mem(8'h42);
		end_test("store offsets");
	endtask

	task automatic addz_and_random();
		int i;
		int pick;
		int rd;
		int rs;
		int rt;
		logic [3:0] imm;
		logic [cpu16_pkg::word_w-1:0] sum;
		if (timed_out) begin
			return;
		end
		begin_test();
		add_instr(itype(cpu16_pkg::op_llb, 1, 5));
		add_instr(itype(cpu16_pkg::op_llb, 2, 5));
		add_instr(itype(cpu16_pkg::op_llb, 3, 7));
		add_instr(itype(cpu16_pkg::op_llb, 6, 'h66));
		// Zero result, first addz writes and clears the flag
		add_instr(rtype(cpu16_pkg::op_sub, 4, 1, 2));
		add_instr(rtype(cpu16_pkg::op_addz, 5, 1, 3));
		add_instr(rtype(cpu16_pkg::op_addz, 6, 1, 3));
		add_instr(rtype(cpu16_pkg::op_add, 7, 6, 0));
		// Random section, r1 is the fixed memory base
		add_instr(itype(cpu16_pkg::op_llb, 1, 'h70));
		for (i = 2; i < 16; i++) begin
			add_instr(itype(cpu16_pkg::op_llb, i, $random(seed)));
		end
		for (i = 0; i < 20; i++) begin
			pick = $unsigned($random(seed)) % 12;
			rd = 2 + $unsigned($random(seed)) % 14;
			rs = $unsigned($random(seed)) % 16;
			rt = $unsigned($random(seed)) % 16;
			if (pick == 8 || pick == 9) begin
				rs = 1;
			end
			if (pick == 9) begin
				rd = $unsigned($random(seed)) % 16;
			end
			if (pick == 8) begin
				// Unwritten word becomes a store instead
				imm = rt[3:0];
				sum = model_reg[1] + {{12{imm[3]}}, imm};
				if (!model_known[sum[7:0]]) begin
					pick = 9;
				end
			end
			if (pick >= 10) begin
				add_instr(itype(4'(pick), rd, $random(seed)));
			end else begin
				add_instr(rtype(4'(pick), rd, rs, rt));
			end
		end
		add_instr(itype(cpu16_pkg::op_hlt, 0, 0));
		run_program();
		for (i = 'h68; i <= 'h77; i++) begin
			if (model_known[i] && !timed_out) begin
				check_mem(i[7:0]);
			end
		end
		end_test("addz and random");
	endtask

	initial begin
		seed = 32'hab45_793e;
		errors = 0;
		checks = 0;
		tests = 0;
		timed_out = 1'b0;
		rst_n <= 1'b0;
		prog_we <= 1'b0;
		prog_addr <= '0;
		prog_data <= '0;
		run <= 1'b0;
		host_addr <= '0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		halt_after_reset();
		alu_chain();
		load_use();
		store_offsets();
		addz_and_random();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// ==== cpu16_top.sv ====
module cpu16_top (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          prog_we,
	input  logic [cpu16_pkg::mem_aw-1:0]  prog_addr,
	input  logic [cpu16_pkg::word_w-1:0]  prog_data,
	input  logic                          run,
	input  logic [cpu16_pkg::mem_aw-1:0]  host_addr,
	output logic [cpu16_pkg::word_w-1:0]  host_rdata,
	output logic                          halted,
	output logic                          retire_valid,
	output logic                          retire_wen,
	output logic [cpu16_pkg::reg_aw-1:0]  retire_reg,
	output logic [cpu16_pkg::word_w-1:0]  retire_data
);

	// Fetch to decode
	logic [cpu16_pkg::word_w-1:0] fetch_instr, if_instr;
	logic [cpu16_pkg::mem_aw-1:0] if_pc, replay_pc;
	logic if_valid, stall;
	// Execute to MEM
	logic ex_valid, ex_wen, ex_is_load, ex_is_store, ex_is_hlt;
	logic [cpu16_pkg::reg_aw-1:0] ex_rd;
	logic [cpu16_pkg::word_w-1:0] ex_result, ex_store_data;
	// Forwarding and register write
	logic mem_fwd_valid, wb_wen;
	logic [cpu16_pkg::reg_aw-1:0] mem_fwd_reg, wb_reg;
	logic [cpu16_pkg::word_w-1:0] mem_fwd_data, wb_data;

	fetch_unit u_fetch (
		.clk, .rst_n, .prog_we, .prog_addr, .prog_data, .run, .stall, .replay_pc,
		.fetch_instr, .if_instr, .if_pc, .if_valid
	);

	// Hazard check runs on the raw fetch stream
	stall_logic u_stall (
		.clk, .rst_n, .instr(fetch_instr), .stall
	);

	execute_unit u_execute (
		.clk, .rst_n, .if_instr, .if_pc, .if_valid, .stall,
		.mem_fwd_valid, .mem_fwd_reg, .mem_fwd_data, .wb_wen, .wb_reg, .wb_data,
		.replay_pc, .ex_valid, .ex_wen, .ex_rd, .ex_result, .ex_store_data,
		.ex_is_load, .ex_is_store, .ex_is_hlt
	);

	mem_writeback u_mem_wb (
		.clk, .rst_n, .ex_valid, .ex_wen, .ex_rd, .ex_result, .ex_store_data,
		.ex_is_load, .ex_is_store, .ex_is_hlt, .host_addr, .host_rdata,
		.mem_fwd_valid, .mem_fwd_reg, .mem_fwd_data, .wb_wen, .wb_reg, .wb_data,
		.retire_valid, .retire_wen, .retire_reg, .retire_data, .halted
	);

endmodule

// ==== mem_writeback.sv ====
module mem_writeback (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          ex_valid,
	input  logic                          ex_wen,
	input  logic [cpu16_pkg::reg_aw-1:0]  ex_rd,
	input  logic [cpu16_pkg::word_w-1:0]  ex_result,
	input  logic [cpu16_pkg::word_w-1:0]  ex_store_data,
	input  logic                          ex_is_load,
	input  logic                          ex_is_store,
	input  logic                          ex_is_hlt,
	input  logic [cpu16_pkg::mem_aw-1:0]  host_addr,
	output logic [cpu16_pkg::word_w-1:0]  host_rdata,
	output logic                          mem_fwd_valid,
	output logic [cpu16_pkg::reg_aw-1:0]  mem_fwd_reg,
	output logic [cpu16_pkg::word_w-1:0]  mem_fwd_data,
	output logic                          wb_wen,
	output logic [cpu16_pkg::reg_aw-1:0]  wb_reg,
	output logic [cpu16_pkg::word_w-1:0]  wb_data,
	output logic                          retire_valid,
	output logic                          retire_wen,
	output logic [cpu16_pkg::reg_aw-1:0]  retire_reg,
	output logic [cpu16_pkg::word_w-1:0]  retire_data,
	output logic                          halted
);

	logic [cpu16_pkg::word_w-1:0] dmem [0:(1 << cpu16_pkg::mem_aw)-1];
	logic [cpu16_pkg::word_w-1:0] load_q;
	logic [cpu16_pkg::word_w-1:0] m_result;
	logic [cpu16_pkg::reg_aw-1:0] m_rd;
	logic m_valid;
	logic m_wen;
	logic m_load;
	logic m_hlt;

	// Load data is not ready yet, so MEM forwards ALU results only
	assign mem_fwd_valid = ex_valid && ex_wen && !ex_is_load;
	assign mem_fwd_reg   = ex_rd;
	assign mem_fwd_data  = ex_result;

	// Data memory, store in MEM, synchronous reads
	always_ff @(posedge clk) begin
		if (ex_valid && ex_is_store) begin
			dmem[ex_result[cpu16_pkg::mem_aw-1:0]] <= ex_store_data;
		end
		load_q     <= dmem[ex_result[cpu16_pkg::mem_aw-1:0]];
		// Host port, one cycle latency
		host_rdata <= dmem[host_addr];
	end

	// MEM register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			{m_valid, m_wen, m_load, m_hlt} <= '0;
		end else begin
			m_valid <= ex_valid;
			m_wen   <= ex_valid && ex_wen;
			m_load  <= ex_is_load;
			m_hlt   <= ex_valid && ex_is_hlt;
		end
	end

	always_ff @(posedge clk) begin
		m_rd     <= ex_rd;
		m_result <= ex_result;
	end

	// Register file write and writeback forward
	assign wb_wen  = m_wen;
	assign wb_reg  = m_rd;
	assign wb_data = m_load ? load_q : m_result;

	// Trace register, one cycle after writeback
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			retire_valid <= 1'b0;
			retire_wen   <= 1'b0;
			halted       <= 1'b0;
		end else begin
			retire_valid <= m_valid;
			retire_wen   <= m_wen;
			// Sticky until reset
			halted       <= halted || (m_valid && m_hlt);
		end
	end

	always_ff @(posedge clk) begin
		retire_reg  <= wb_reg;
		retire_data <= wb_data;
	end

endmodule

// ==== execute_unit.sv ====
module execute_unit (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [cpu16_pkg::word_w-1:0]  if_instr,
	input  logic [cpu16_pkg::mem_aw-1:0]  if_pc,
	input  logic                          if_valid,
	input  logic                          stall,
	input  logic                          mem_fwd_valid,
	input  logic [cpu16_pkg::reg_aw-1:0]  mem_fwd_reg,
	input  logic [cpu16_pkg::word_w-1:0]  mem_fwd_data,
	input  logic                          wb_wen,
	input  logic [cpu16_pkg::reg_aw-1:0]  wb_reg,
	input  logic [cpu16_pkg::word_w-1:0]  wb_data,
	output logic [cpu16_pkg::mem_aw-1:0]  replay_pc,
	output logic                          ex_valid,
	output logic                          ex_wen,
	output logic [cpu16_pkg::reg_aw-1:0]  ex_rd,
	output logic [cpu16_pkg::word_w-1:0]  ex_result,
	output logic [cpu16_pkg::word_w-1:0]  ex_store_data,
	output logic                          ex_is_load,
	output logic                          ex_is_store,
	output logic                          ex_is_hlt
);

	logic [cpu16_pkg::word_w-1:0] rf [0:(1 << cpu16_pkg::reg_aw)-1];
	logic [3:0] op;
	logic [cpu16_pkg::reg_aw-1:0] rd, rs, rt, src2;
	logic [7:0] imm8;
	cpu16_pkg::alu_op_t alu_dec, d_alu;
	logic [cpu16_pkg::word_w-1:0] imm_dec, rs_val, src2_val;
	logic wen_dec, use_imm_dec, load_dec, store_dec, hlt_dec, zset_dec, dec_valid;
	// Decode register
	logic d_valid, d_wen, d_load, d_store, d_hlt, d_zset, d_addz, d_use_imm;
	logic [cpu16_pkg::reg_aw-1:0] d_rd, d_rs, d_src2;
	logic [cpu16_pkg::word_w-1:0] d_a, d_b, d_imm;
	// Execute stage
	logic [cpu16_pkg::word_w-1:0] fwd_a, fwd_b, b_op, alu_y;
	logic zero_flag, write_ok;

	// Decode stage pc, refetched after a stall
	assign replay_pc = if_pc;

	assign op   = if_instr[cpu16_pkg::op_hi:cpu16_pkg::op_lo];
	assign rd   = if_instr[cpu16_pkg::rd_hi:cpu16_pkg::rd_lo];
	assign rs   = if_instr[cpu16_pkg::rs_hi:cpu16_pkg::rs_lo];
	assign rt   = if_instr[cpu16_pkg::rt_hi:cpu16_pkg::rt_lo];
	assign imm8 = if_instr[cpu16_pkg::imm8_hi:cpu16_pkg::imm8_lo];
	// sw takes its data from the rd field
	assign src2 = (op == cpu16_pkg::op_sw) ? rd : rt;
	assign dec_valid = if_valid && !stall;

	always_comb begin
		alu_dec = cpu16_pkg::alu_pass;
		imm_dec = '0;
		{wen_dec, use_imm_dec, load_dec, store_dec, hlt_dec, zset_dec} = 6'b100000;
		case (op)
			cpu16_pkg::op_add, cpu16_pkg::op_addz: {alu_dec, zset_dec} = {cpu16_pkg::alu_add, 1'b1};
			cpu16_pkg::op_sub: {alu_dec, zset_dec} = {cpu16_pkg::alu_sub, 1'b1};
			cpu16_pkg::op_and: {alu_dec, zset_dec} = {cpu16_pkg::alu_and, 1'b1};
			cpu16_pkg::op_nor: {alu_dec, zset_dec} = {cpu16_pkg::alu_nor, 1'b1};
			cpu16_pkg::op_sll, cpu16_pkg::op_srl, cpu16_pkg::op_sra: begin
				// Shift amount is the raw imm4
				alu_dec = (op == cpu16_pkg::op_sll) ? cpu16_pkg::alu_sll :
					(op == cpu16_pkg::op_srl) ? cpu16_pkg::alu_srl : cpu16_pkg::alu_sra;
				use_imm_dec = 1'b1;
				imm_dec = {{(cpu16_pkg::word_w-4){1'b0}}, rt};
			end
			cpu16_pkg::op_lw, cpu16_pkg::op_sw: begin
				// Address is rs plus signed imm4
				alu_dec = cpu16_pkg::alu_add;
				use_imm_dec = 1'b1;
				imm_dec = {{(cpu16_pkg::word_w-4){rt[3]}}, rt};
				load_dec = op == cpu16_pkg::op_lw;
				store_dec = op == cpu16_pkg::op_sw;
				wen_dec = op == cpu16_pkg::op_lw;
			end
			cpu16_pkg::op_lhb: {use_imm_dec, imm_dec} = {1'b1, imm8, 8'h00};
			cpu16_pkg::op_llb: {use_imm_dec, imm_dec} = {1'b1, {8{imm8[7]}}, imm8};
			cpu16_pkg::op_hlt: {wen_dec, hlt_dec} = 2'b01;
			// Branch and jump group
			cpu16_pkg::op_b, cpu16_pkg::op_jal, cpu16_pkg::op_jr: wen_dec = 1'b0;
			default: wen_dec = 1'b0;
		endcase
	end

	// R0 reads zero, writeback bypassed into the read
	assign rs_val = (rs == '0) ? '0 : (wb_wen && wb_reg == rs) ? wb_data : rf[rs];
	assign src2_val = (src2 == '0) ? '0 : (wb_wen && wb_reg == src2) ? wb_data : rf[src2];

	always_ff @(posedge clk) begin
		if (wb_wen) begin
			rf[wb_reg] <= wb_data;
		end
	end

	// Decode register, stall turns it into a bubble
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			{d_valid, d_wen, d_load, d_store, d_hlt, d_zset, d_addz} <= '0;
		end else begin
			d_valid <= dec_valid;
			d_wen   <= dec_valid && wen_dec;
			d_load  <= dec_valid && load_dec;
			d_store <= dec_valid && store_dec;
			d_hlt   <= dec_valid && hlt_dec;
			d_zset  <= dec_valid && zset_dec;
			d_addz  <= dec_valid && (op == cpu16_pkg::op_addz);
		end
	end

	always_ff @(posedge clk) begin
		{d_alu, d_use_imm, d_imm} <= {alu_dec, use_imm_dec, imm_dec};
		{d_rd, d_rs, d_src2} <= {rd, rs, src2};
		{d_a, d_b} <= {rs_val, src2_val};
	end

	// Forward from MEM first, then writeback
	assign fwd_a = (d_rs != '0 && mem_fwd_valid && mem_fwd_reg == d_rs) ? mem_fwd_data :
		(d_rs != '0 && wb_wen && wb_reg == d_rs) ? wb_data : d_a;
	assign fwd_b = (d_src2 != '0 && mem_fwd_valid && mem_fwd_reg == d_src2) ? mem_fwd_data :
		(d_src2 != '0 && wb_wen && wb_reg == d_src2) ? wb_data : d_b;
	assign b_op = d_use_imm ? d_imm : fwd_b;

	always_comb begin
		case (d_alu)
			cpu16_pkg::alu_add: alu_y = fwd_a + b_op;
			cpu16_pkg::alu_sub: alu_y = fwd_a - b_op;
			cpu16_pkg::alu_and: alu_y = fwd_a & b_op;
			cpu16_pkg::alu_nor: alu_y = ~(fwd_a | b_op);
			cpu16_pkg::alu_sll: alu_y = fwd_a << b_op[3:0];
			cpu16_pkg::alu_srl: alu_y = fwd_a >> b_op[3:0];
			cpu16_pkg::alu_sra: alu_y = $signed(fwd_a) >>> b_op[3:0];
			default: alu_y = b_op;
		endcase
	end

	// addz writes only on a set zero flag
	assign write_ok = !d_addz || zero_flag;

	// Zero flag and execute register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			zero_flag <= 1'b0;
			{ex_valid, ex_wen, ex_is_load, ex_is_store, ex_is_hlt} <= '0;
		end else begin
			if (d_zset && write_ok) begin
				zero_flag <= alu_y == '0;
			end
			ex_valid    <= d_valid;
			ex_wen      <= d_wen && write_ok;
			ex_is_load  <= d_load;
			ex_is_store <= d_store;
			ex_is_hlt   <= d_hlt;
		end
	end

	always_ff @(posedge clk) begin
		ex_rd         <= d_rd;
		ex_result     <= alu_y;
		ex_store_data <= fwd_b;
	end

endmodule

// ==== stall_logic.sv ====
module stall_logic (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [cpu16_pkg::word_w-1:0]  instr,
	output logic                          stall
);

	logic [cpu16_pkg::word_w-1:0] curr_instr;
	logic [cpu16_pkg::word_w-1:0] prev_instr;
	cpu16_pkg::stall_state_t state;
	cpu16_pkg::stall_state_t next_state;
	logic [3:0] curr_op;
	logic [3:0] prev_op;
	logic [cpu16_pkg::reg_aw-1:0] curr_src1;
	logic [cpu16_pkg::reg_aw-1:0] curr_src2;
	logic [cpu16_pkg::reg_aw-1:0] curr_src_sw;
	logic [cpu16_pkg::reg_aw-1:0] prev_dest;
	logic two_sources;
	logic one_source;
	logic store_source;
	logic hazard;

	// Curr tracks decode, prev tracks execute
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			curr_instr <= cpu16_pkg::nop_instr;
			prev_instr <= cpu16_pkg::nop_instr;
		end else begin
			curr_instr <= instr;
			prev_instr <= curr_instr;
		end
	end

	// Field split
	assign curr_op     = curr_instr[cpu16_pkg::op_hi:cpu16_pkg::op_lo];
	assign curr_src1   = curr_instr[cpu16_pkg::rs_hi:cpu16_pkg::rs_lo];
	assign curr_src2   = curr_instr[cpu16_pkg::rt_hi:cpu16_pkg::rt_lo];
	assign curr_src_sw = curr_instr[cpu16_pkg::rd_hi:cpu16_pkg::rd_lo];
	assign prev_op     = prev_instr[cpu16_pkg::op_hi:cpu16_pkg::op_lo];
	assign prev_dest   = prev_instr[cpu16_pkg::rd_hi:cpu16_pkg::rd_lo];

	// Which register fields the decode instruction reads
	assign two_sources = (curr_op == cpu16_pkg::op_add) || (curr_op == cpu16_pkg::op_addz) ||
		(curr_op == cpu16_pkg::op_sub) || (curr_op == cpu16_pkg::op_and) ||
		(curr_op == cpu16_pkg::op_nor);
	assign one_source = (curr_op == cpu16_pkg::op_sll) || (curr_op == cpu16_pkg::op_srl) ||
		(curr_op == cpu16_pkg::op_sra) || (curr_op == cpu16_pkg::op_lw);
	// sw reads its data register from rd
	assign store_source = curr_op == cpu16_pkg::op_sw;

	// Load followed by a reader of its destination
	assign hazard = (prev_op == cpu16_pkg::op_lw) &&
		((two_sources && ((prev_dest == curr_src1) || (prev_dest == curr_src2))) ||
		(one_source && (prev_dest == curr_src1)) ||
		(store_source && (prev_dest == curr_src_sw)));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= cpu16_pkg::st_start;
		end else begin
			state <= next_state;
		end
	end

	// One stall cycle per hazard
	always_comb begin
		next_state = cpu16_pkg::st_start;
		stall      = 1'b0;
		case (state)
			// Shift register fills during this cycle
			cpu16_pkg::st_start: next_state = cpu16_pkg::st_no_stall;
			cpu16_pkg::st_no_stall: begin
				if (hazard) begin
					next_state = cpu16_pkg::st_stall;
					stall      = 1'b1;
				end else begin
					next_state = cpu16_pkg::st_no_stall;
				end
			end
			// Pair still holds the squashed slot, hazard ignored
			cpu16_pkg::st_stall: next_state = cpu16_pkg::st_no_stall;
			cpu16_pkg::st_unused: next_state = cpu16_pkg::st_start;
			default: next_state = cpu16_pkg::st_start;
		endcase
	end

endmodule

// ==== fetch_unit.sv ====
module fetch_unit (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          prog_we,
	input  logic [cpu16_pkg::mem_aw-1:0]  prog_addr,
	input  logic [cpu16_pkg::word_w-1:0]  prog_data,
	input  logic                          run,
	input  logic                          stall,
	input  logic [cpu16_pkg::mem_aw-1:0]  replay_pc,
	output logic [cpu16_pkg::word_w-1:0]  fetch_instr,
	output logic [cpu16_pkg::word_w-1:0]  if_instr,
	output logic [cpu16_pkg::mem_aw-1:0]  if_pc,
	output logic                          if_valid
);

	logic [cpu16_pkg::word_w-1:0] imem [0:(1 << cpu16_pkg::mem_aw)-1];
	logic [cpu16_pkg::word_w-1:0] mem_word;
	logic [cpu16_pkg::mem_aw-1:0] pc;
	logic run_q;
	logic fetching;
	logic active;
	logic is_hlt;

	// Host program load, only while idle
	always_ff @(posedge clk) begin
		if (prog_we && !run) begin
			imem[prog_addr] <= prog_data;
		end
	end

	// Word at the current pc
	assign mem_word = imem[pc];
	// A stall squashes this slot
	assign active = fetching && !stall;
	// Stall logic sees a bubble whenever nothing real is fetched
	assign fetch_instr = active ? mem_word : cpu16_pkg::nop_instr;
	assign is_hlt = mem_word[cpu16_pkg::op_hi:cpu16_pkg::op_lo] == cpu16_pkg::op_hlt;

	// Program counter and fetch enable
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			run_q    <= 1'b0;
			fetching <= 1'b0;
			pc       <= '0;
		end else begin
			run_q <= run;
			if (run && !run_q) begin
				// Rising edge of run restarts at word 0
				fetching <= 1'b1;
				pc       <= '0;
			end else if (!run || (active && is_hlt)) begin
				fetching <= 1'b0;
			end else if (stall) begin
				// Refetch the dependent instruction
				pc <= replay_pc;
			end else if (fetching) begin
				pc <= pc + 1'b1;
			end
		end
	end

	// Fetch register, bubble when inactive
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			if_valid <= 1'b0;
		end else begin
			if_valid <= active;
		end
	end

	always_ff @(posedge clk) begin
		if_instr <= fetch_instr;
		if_pc    <= pc;
	end

endmodule

// ==== cpu16_pkg.sv ====
package cpu16_pkg;

	// Datapath widths
	localparam int word_w = 16;
	localparam int reg_aw = 4;
	// Both memories hold 256 words
	localparam int mem_aw = 8;

	// Opcodes
	localparam logic [3:0] op_add  = 4'h0;
	localparam logic [3:0] op_addz = 4'h1;
	localparam logic [3:0] op_sub  = 4'h2;
	localparam logic [3:0] op_and  = 4'h3;
	localparam logic [3:0] op_nor  = 4'h4;
	localparam logic [3:0] op_sll  = 4'h5;
	localparam logic [3:0] op_srl  = 4'h6;
	localparam logic [3:0] op_sra  = 4'h7;
	localparam logic [3:0] op_lw   = 4'h8;
	localparam logic [3:0] op_sw   = 4'h9;
	localparam logic [3:0] op_lhb  = 4'hA;
	localparam logic [3:0] op_llb  = 4'hB;
	// Control flow group, executed as no-ops
	localparam logic [3:0] op_b    = 4'hC;
	localparam logic [3:0] op_jal  = 4'hD;
	localparam logic [3:0] op_jr   = 4'hE;
	localparam logic [3:0] op_hlt  = 4'hF;

	// Instruction field positions
	localparam int op_hi   = 15;
	localparam int op_lo   = 12;
	localparam int rd_hi   = 11;
	localparam int rd_lo   = 8;
	localparam int rs_hi   = 7;
	localparam int rs_lo   = 4;
	// Also the imm4 field
	localparam int rt_hi   = 3;
	localparam int rt_lo   = 0;
	localparam int imm8_hi = 7;
	localparam int imm8_lo = 0;

	// Bubble word
	localparam logic [word_w-1:0] nop_instr = {op_b, 12'h000};

	// Load-use stall FSM
	typedef enum logic [1:0] {
		st_start,
		st_no_stall,
		st_stall,
		st_unused
	} stall_state_t;

	// ALU operations
	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_nor,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_pass
	} alu_op_t;

endpackage
